//--- common/hight_pkg.sv
package hight_pkg;

	// ************************************************************************
	// Data types
	// ************************************************************************

	// One cipher block. Byte 7 is the most significant byte.
	typedef logic [7:0][7:0] block_t;

	// Master key. Element n is MK n, so MK15 sits in the top byte.
	typedef logic [15:0][7:0] key_t;

	// Four 8-bit keys, either the round subkeys or one whitening group.
	typedef logic [3:0][7:0] subkey_t;

	// One cipher request as it arrives with the start pulse.
	typedef struct packed {
		logic   op;    // 0 encrypts, 1 decrypts.
		key_t   key;
		block_t data;
	} hight_req_t;

	// ************************************************************************
	// Cipher constants
	// ************************************************************************

	localparam int HIGHT_ROUNDS = 32;
	localparam int RND_W = $clog2(HIGHT_ROUNDS);

	// Delta constants come from a 7-bit LFSR, x^7 + x^3 + 1.
	localparam int DELTA_W = 7;
	localparam logic [DELTA_W-1:0] DELTA_INIT = 7'h5A;

	// Value after 127 steps, the delta of subkey 127.
	// The sequence has a period of 127, so it lands on the start value again.
	localparam logic [DELTA_W-1:0] DELTA_LAST = 7'h5A;

endpackage

//--- hight_round/hight_round.sv
`timescale 1ns/100ps

module hight_round import hight_pkg::*; (
	input  logic    i_op,
	input  subkey_t i_rsk,
	input  block_t  i_rf_in,
	input  logic    i_rf_final,
	output block_t  o_rf_out
);

	// ************************************************************************
	// Mixing functions
	// ************************************************************************

	// F0 is the XOR of the byte rotated left by 1, 2 and 7.
	function automatic logic [7:0] f0(input logic [7:0] x);
		return {x[6:0], x[7]} ^ {x[5:0], x[7:6]} ^ {x[0], x[7:1]};
	endfunction

	// F1 is the XOR of the byte rotated left by 3, 4 and 6.
	function automatic logic [7:0] f1(input logic [7:0] x);
		return {x[4:0], x[7:5]} ^ {x[3:0], x[7:4]} ^ {x[1:0], x[7:2]};
	endfunction

	logic [7:0] f0_6;
	logic [7:0] f1_4;
	logic [7:0] f0_2;
	logic [7:0] f1_0;
	logic [7:0] mv [0:3];  // New odd bytes 7, 5, 3 and 1.
	block_t     mixed;

	// Only the even bytes feed the functions, so they are the same both ways.
	assign f0_6 = f0(i_rf_in[6]);
	assign f1_4 = f1(i_rf_in[4]);
	assign f0_2 = f0(i_rf_in[2]);
	assign f1_0 = f1(i_rf_in[0]);

	// ************************************************************************
	// Subkey merge into the odd bytes
	// ************************************************************************

	// Decryption reads the subkey word in reverse byte order.
	assign mv[3] = i_op ? i_rf_in[7] ^ (f0_6 + i_rsk[0]) :
	                      i_rf_in[7] ^ (f0_6 + i_rsk[3]);

	assign mv[2] = i_op ? i_rf_in[5] - (f1_4 ^ i_rsk[1]) :
	                      i_rf_in[5] + (f1_4 ^ i_rsk[2]);

	assign mv[1] = i_op ? i_rf_in[3] ^ (f0_2 + i_rsk[2]) :
	                      i_rf_in[3] ^ (f0_2 + i_rsk[1]);

	assign mv[0] = i_op ? i_rf_in[1] - (f1_0 ^ i_rsk[3]) :
	                      i_rf_in[1] + (f1_0 ^ i_rsk[0]);

	assign mixed = {mv[3], i_rf_in[6], mv[2], i_rf_in[4],
	                mv[1], i_rf_in[2], mv[0], i_rf_in[0]};

	// ************************************************************************
	// Byte rotation
	// ************************************************************************

	// Encryption rotates one byte left, decryption one byte right.
	// The last round of either direction keeps the bytes in place.
	always_comb begin
		if (i_rf_final) begin
			o_rf_out = mixed;
		end else if (i_op) begin
			o_rf_out = {mixed[0], mixed[7:1]};
		end else begin
			o_rf_out = {mixed[6:0], mixed[7]};
		end
	end

endmodule

//--- hight_key/hight_key_sched.sv
`timescale 1ns/100ps

module hight_key_sched import hight_pkg::*; (
	input  logic    i_clk,
	input  logic    i_rst,
	input  logic    i_load,
	input  logic    i_step,
	input  logic    i_op,
	input  key_t    i_key,
	output subkey_t o_wk_pre,
	output subkey_t o_wk_post,
	output subkey_t o_rsk
);

	// One forward step shifts in s(i+7) = s(i+3) ^ s(i) at the top.
	function automatic logic [DELTA_W-1:0] lfsr_fwd(input logic [DELTA_W-1:0] d);
		return {d[3] ^ d[0], d[6:1]};
	endfunction

	// The backward step recovers s(i) = s(i+7) ^ s(i+3) at the bottom.
	function automatic logic [DELTA_W-1:0] lfsr_bwd(input logic [DELTA_W-1:0] d);
		return {d[5:0], d[6] ^ d[2]};
	endfunction

	subkey_t            wk_lo;  // WK0 to WK3.
	subkey_t            wk_hi;  // WK4 to WK7.
	logic [DELTA_W-1:0] delta_q;
	logic [RND_W-1:0]   idx_q;
	logic [DELTA_W-1:0] d      [0:4];
	logic [RND_W+1:0]   sk_idx [0:3];
	logic [3:0]         mk_sel [0:3];
	logic [7:0]         sk     [0:3];

	// ************************************************************************
	// Whitening keys
	// ************************************************************************

	assign wk_lo = i_key[15:12];
	assign wk_hi = i_key[3:0];

	// Decryption undoes the final transform first.
	assign o_wk_pre  = i_op ? wk_hi : wk_lo;
	assign o_wk_post = i_op ? wk_lo : wk_hi;

	// ************************************************************************
	// Delta LFSR and round index
	// ************************************************************************

	// The register holds the first delta of the round in the direction of
	// travel, delta 4r going up or delta 4r+3 going down.
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			delta_q <= DELTA_INIT;
			idx_q   <= '0;
		end else if (i_load) begin
			delta_q <= i_op ? DELTA_LAST : DELTA_INIT;
			idx_q   <= i_op ? RND_W'(HIGHT_ROUNDS - 1) : '0;
		end else if (i_step) begin
			delta_q <= d[4];  // Four steps per round.
			idx_q   <= i_op ? idx_q - 1'b1 : idx_q + 1'b1;
		end
	end

	// ************************************************************************
	// Round subkeys
	// ************************************************************************

	// Subkey 16i+j takes MK((j-i) mod 8), and MK((j-i) mod 8 + 8) for 16i+j+8.
	// Position p is taken in step order, so the packed word comes out in
	// natural order when encrypting and reversed when decrypting.
	always_comb begin
		d[0] = delta_q;
		for (int p = 0; p < 4; p++) begin
			d[p+1]         = i_op ? lfsr_bwd(d[p]) : lfsr_fwd(d[p]);
			sk_idx[p]      = i_op ? {idx_q, 2'(3 - p)} : {idx_q, 2'(p)};
			mk_sel[p][3]   = sk_idx[p][3];
			mk_sel[p][2:0] = sk_idx[p][2:0] - sk_idx[p][6:4];
			sk[p]          = i_key[mk_sel[p]] + {1'b0, d[p]};
		end
	end

	assign o_rsk = {sk[3], sk[2], sk[1], sk[0]};

endmodule

//--- source/hight_whiten.sv
`timescale 1ns/100ps

module hight_whiten import hight_pkg::*; (
	input  logic    i_op,
	input  subkey_t i_wk,
	input  block_t  i_blk,
	output block_t  o_blk
);

	logic [7:0] arith_0;
	logic [7:0] arith_4;
	logic [7:0] xor_2;
	logic [7:0] xor_6;

	// ************************************************************************
	// Key mixing on the even bytes
	// ************************************************************************

	// Bytes 0 and 4 use modular add, inverted by subtract on the way back.
	assign arith_0 = i_op ? i_blk[0] - i_wk[0] : i_blk[0] + i_wk[0];
	assign arith_4 = i_op ? i_blk[4] - i_wk[2] : i_blk[4] + i_wk[2];

	// XOR is its own inverse.
	assign xor_2 = i_blk[2] ^ i_wk[1];
	assign xor_6 = i_blk[6] ^ i_wk[3];

	always_comb begin
		o_blk    = i_blk;  // Odd bytes pass through.
		o_blk[0] = arith_0;
		o_blk[2] = xor_2;
		o_blk[4] = arith_4;
		o_blk[6] = xor_6;
	end

endmodule

//--- source/hight_core.sv
`timescale 1ns/100ps

module hight_core import hight_pkg::*; (
	input  logic       i_clk,
	input  logic       i_rst,
	input  logic       i_start,
	input  hight_req_t i_req,
	output logic       o_busy,
	output logic       o_done,
	output block_t     o_data
);

	hight_req_t       req_q;
	logic             accept;
	logic             load_q;    // High in the cycle after an accepted start.
	logic             run_q;     // High over the 32 round cycles.
	logic [RND_W-1:0] rnd_q;
	logic             last_rnd;
	logic             fin_rnd;
	block_t           state_q;
	block_t           pre_blk;
	block_t           round_out;
	block_t           post_blk;
	subkey_t          wk_pre;
	subkey_t          wk_post;
	subkey_t          rsk;

	assign accept   = i_start & ~o_busy;  // Starts during a run are dropped.
	assign last_rnd = (rnd_q == RND_W'(HIGHT_ROUNDS - 1));
	assign fin_rnd  = run_q & last_rnd;

	// ************************************************************************
	// Control
	// ************************************************************************

	always_ff @(posedge i_clk) begin
		if (accept) begin
			req_q <= i_req;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_busy <= 1'b0;
			o_done <= 1'b0;
			load_q <= 1'b0;
			run_q  <= 1'b0;
			rnd_q  <= '0;
		end else begin
			load_q <= accept;
			o_done <= fin_rnd;
			if (accept) begin
				o_busy <= 1'b1;
			end else if (o_done) begin
				o_busy <= 1'b0;  // Busy covers the done cycle too.
			end
			if (load_q) begin
				run_q <= 1'b1;
				rnd_q <= '0;
			end else if (run_q) begin
				rnd_q <= rnd_q + 1'b1;
				if (last_rnd) begin
					run_q <= 1'b0;
				end
			end
		end
	end

	// ************************************************************************
	// Datapath
	// ************************************************************************

	always_ff @(posedge i_clk) begin
		if (load_q) begin
			state_q <= pre_blk;
		end else if (run_q) begin
			state_q <= round_out;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_data <= '0;
		end else if (fin_rnd) begin
			o_data <= post_blk;  // Held until the next result.
		end
	end

	hight_key_sched key_sched_i (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_load    (load_q),
		.i_step    (run_q),
		.i_op      (req_q.op),
		.i_key     (req_q.key),
		.o_wk_pre  (wk_pre),
		.o_wk_post (wk_post),
		.o_rsk     (rsk)
	);

	hight_whiten pre_whiten_i (
		.i_op  (req_q.op),
		.i_wk  (wk_pre),
		.i_blk (req_q.data),
		.o_blk (pre_blk)
	);

	hight_round round_i (
		.i_op       (req_q.op),
		.i_rsk      (rsk),
		.i_rf_in    (state_q),
		.i_rf_final (fin_rnd),
		.o_rf_out   (round_out)
	);

	hight_whiten post_whiten_i (
		.i_op  (req_q.op),
		.i_wk  (wk_post),
		.i_blk (round_out),
		.o_blk (post_blk)
	);

endmodule

//--- test/hight_model.svh
`ifndef HIGHT_MODEL_SVH
`define HIGHT_MODEL_SVH

// ************************************************************************
// Reference model of the cipher
// ************************************************************************

logic [31:0] rng_state;

function automatic logic [7:0] rotl8(input logic [7:0] x, input int n);
	return (x << n) | (x >> (8 - n));
endfunction

function automatic logic [7:0] mix_f0(input logic [7:0] x);
	return rotl8(x, 1) ^ rotl8(x, 2) ^ rotl8(x, 7);
endfunction

function automatic logic [7:0] mix_f1(input logic [7:0] x);
	return rotl8(x, 3) ^ rotl8(x, 4) ^ rotl8(x, 6);
endfunction

// Subkey n = 16i+j, built from the delta sequence that starts at 0x5A.
function automatic logic [7:0] subkey(input key_t key, input int n);
	logic [6:0] d;
	logic [3:0] mk;
	int         i;
	int         j;
	d = 7'h5A;
	for (int k = 0; k < n; k++) begin
		d = {d[3] ^ d[0], d[6:1]};  // New top bit is s(i+3) xor s(i).
	end
	i = n / 16;
	j = n % 16;
	mk = {1'(j / 8), 3'(j - i)};
	return key[mk] + {1'b0, d};
endfunction

function automatic block_t encrypt(input key_t key, input block_t pt);
	block_t x;
	block_t y;
	x = pt;
	x[0] = pt[0] + key[12];
	x[2] = pt[2] ^ key[13];
	x[4] = pt[4] + key[14];
	x[6] = pt[6] ^ key[15];
	for (int r = 0; r < 31; r++) begin
		y[1] = x[0];
		y[3] = x[2];
		y[5] = x[4];
		y[7] = x[6];
		y[0] = x[7] ^ (mix_f0(x[6]) + subkey(key, 4 * r + 3));
		y[2] = x[1] + (mix_f1(x[0]) ^ subkey(key, 4 * r));
		y[4] = x[3] ^ (mix_f0(x[2]) + subkey(key, 4 * r + 1));
		y[6] = x[5] + (mix_f1(x[4]) ^ subkey(key, 4 * r + 2));
		x = y;
	end
	// The last round keeps the byte order.
	x[1] = x[1] + (mix_f1(x[0]) ^ subkey(key, 124));
	x[3] = x[3] ^ (mix_f0(x[2]) + subkey(key, 125));
	x[5] = x[5] + (mix_f1(x[4]) ^ subkey(key, 126));
	x[7] = x[7] ^ (mix_f0(x[6]) + subkey(key, 127));
	x[0] = x[0] + key[0];
	x[2] = x[2] ^ key[1];
	x[4] = x[4] + key[2];
	x[6] = x[6] ^ key[3];
	return x;
endfunction

// Each encryption step undone in reverse order.
function automatic block_t decrypt(input key_t key, input block_t ct);
	block_t x;
	block_t y;
	x = ct;
	x[0] = ct[0] - key[0];
	x[2] = ct[2] ^ key[1];
	x[4] = ct[4] - key[2];
	x[6] = ct[6] ^ key[3];
	x[1] = x[1] - (mix_f1(x[0]) ^ subkey(key, 124));
	x[3] = x[3] ^ (mix_f0(x[2]) + subkey(key, 125));
	x[5] = x[5] - (mix_f1(x[4]) ^ subkey(key, 126));
	x[7] = x[7] ^ (mix_f0(x[6]) + subkey(key, 127));
	for (int r = 30; r >= 0; r--) begin
		y[0] = x[1];
		y[2] = x[3];
		y[4] = x[5];
		y[6] = x[7];
		y[7] = x[0] ^ (mix_f0(y[6]) + subkey(key, 4 * r + 3));
		y[1] = x[2] - (mix_f1(y[0]) ^ subkey(key, 4 * r));
		y[3] = x[4] ^ (mix_f0(y[2]) + subkey(key, 4 * r + 1));
		y[5] = x[6] - (mix_f1(y[4]) ^ subkey(key, 4 * r + 2));
		x = y;
	end
	x[0] = x[0] - key[12];
	x[2] = x[2] ^ key[13];
	x[4] = x[4] - key[14];
	x[6] = x[6] ^ key[15];
	return x;
endfunction

// Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit taken.
function automatic logic [63:0] rand_bits(input int n);
	logic [63:0] v;
	v = '0;
	for (int i = 0; i < n; i++) begin
		v = {v[62:0], rng_state[0]};
		rng_state = rng_state[0] ? (rng_state >> 1) ^ 32'h80200003 : rng_state >> 1;
	end
	return v;
endfunction

`endif

//--- test/hight_tb.sv
`timescale 1ns/100ps

module hight_tb import hight_pkg::*; ();

	localparam int N_RAND  = 20;
	localparam int MAX_GAP = 7;
	localparam int LATENCY = 33;
	localparam int N_REQ   = 2 + 2 * N_RAND;  // Each encryption is followed by its round trip.
	localparam int TIMEOUT = N_REQ * (LATENCY + MAX_GAP + 2) + 100;

	localparam key_t   KAT_KEY = 128'h00112233445566778899aabbccddeeff;
	localparam block_t KAT_CT  = 64'h00f418aed94f03f2;

	logic       i_clk;
	logic       i_rst;
	logic       i_start;
	hight_req_t i_req;
	logic       o_busy;
	logic       o_done;
	block_t     o_data;
	block_t     held = '0;
	int         checks = 0;
	int         errors = 0;
	int         cycles = 0;

	`include "hight_model.svh"

	hight_core hight_core_i (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_start (i_start),
		.i_req   (i_req),
		.o_busy  (o_busy),
		.o_done  (o_done),
		.o_data  (o_data)
	);

	initial begin
		i_clk = 1'b0;
		forever #10 i_clk = ~i_clk;
	end

	always @(posedge i_clk) begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT) begin
			$display("Run timed out after %0d cycles without a result from the DUT.", TIMEOUT);
			$display("Checks: %0d, errors: %0d", checks, errors);
			$display("Result: FAILED");
			$finish;
		end
	end

	task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s, got %h, expected %h", $time, what, got, exp);
		end
	endtask

	// ************************************************************************
	// One request from start pulse to the cycle after done
	// ************************************************************************

	task automatic run_req(input logic op, input key_t key, input block_t data,
			input block_t exp, input int gap, input logic inject);
		hight_req_t req;
		int         n;
		req.op   = op;
		req.key  = key;
		req.data = data;
		repeat (gap) begin
			@(posedge i_clk);
			@(negedge i_clk);
			check(o_data, held, "result held between requests");
		end
		@(posedge i_clk);
		i_start <= 1'b1;
		i_req   <= req;
		n = -1;  // The first edge in the loop is the one that takes the request.
		do begin
			@(posedge i_clk);
			i_start <= inject && (n == 5);  // A second start while busy.
			if (inject && n == 5) begin
				i_req <= ~req;
			end
			@(negedge i_clk);
			n++;
			if (!o_done) begin
				check(64'(o_busy), 64'd1, "busy during run");
			end
		end while (!o_done);
		check(64'(n), 64'(LATENCY), "start to done latency");
		check(64'(o_busy), 64'd1, "busy in done cycle");
		if (op) begin
			check(o_data, exp, "decrypt result");
		end else begin
			check(o_data, exp, "encrypt result");
		end
		held = exp;
		@(posedge i_clk);
		@(negedge i_clk);
		check(64'(o_busy), 64'd0, "busy after done");
		check(64'(o_done), 64'd0, "done pulse width");
		check(o_data, held, "result held after done");
	endtask

	initial begin : stimulus
		key_t        key;
		block_t      data;
		block_t      ct;
		logic [63:0] k_hi;
		logic [63:0] k_lo;
		logic        op;
		logic        inject;
		int          gap;
		rng_state = 32'd94;
		i_rst     = 1'b1;
		i_start   = 1'b0;
		i_req     = '0;

		check(encrypt(KAT_KEY, '0), KAT_CT, "model known answer encrypt");
		check(decrypt(KAT_KEY, KAT_CT), '0, "model known answer decrypt");

		repeat (16) @(posedge i_clk);
		i_rst <= 1'b0;
		@(negedge i_clk);
		check(64'(o_busy), 64'd0, "busy after reset");
		check(64'(o_done), 64'd0, "done after reset");
		check(o_data, '0, "data after reset");

		run_req(1'b0, KAT_KEY, '0, KAT_CT, 0, 1'b0);
		run_req(1'b1, KAT_KEY, KAT_CT, '0, 0, 1'b1);

		for (int t = 0; t < N_RAND; t++) begin
			op     = 1'(rand_bits(1));
			k_hi   = rand_bits(64);
			k_lo   = rand_bits(64);
			key    = {k_hi, k_lo};
			data   = rand_bits(64);
			gap    = int'(rand_bits(3));
			inject = 1'(rand_bits(1));
			if (op) begin
				run_req(1'b1, key, data, decrypt(key, data), gap, inject);
			end else begin
				ct = encrypt(key, data);
				run_req(1'b0, key, data, ct, gap, inject);
				run_req(1'b1, key, ct, data, 0, 1'b0);  // Round trip.
			end
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

//--- project.f
+incdir+test
common/hight_pkg.sv
hight_round/hight_round.sv
hight_key/hight_key_sched.sv
source/hight_whiten.sv
source/hight_core.sv
test/hight_tb.sv

//--- Makefile
# Verilator flow for the HIGHT core and its testbench.

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/100ps -f project.f \
		--top-module hight_core

sim:
	verilator --binary --timing --timescale 1ns/100ps -f project.f \
		--top-module hight_tb -o hight_sim
	./obj_dir/hight_sim | tee sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
